// File: verilog/dccm_consts.svh
// two 32-bit banks with 7 check bits each; bank select sits right above the byte offset
`ifndef DCCM_CONSTS_SVH
`define DCCM_CONSTS_SVH

// memory geometry
`define DCCM_BITS          16    // byte address width
`define DCCM_DATA_WIDTH    32    // data bits per bank
`define DCCM_ECC_WIDTH     7     // check bits per bank
`define DCCM_FDATA_WIDTH   39    // bank word with check bits on top
`define DCCM_BYTE_WIDTH    4     // bytes per bank
`define DCCM_WIDTH_BITS    2     // byte offset bits
`define DCCM_BANK_BITS     1     // bank select bits

// access size codes
`define SIZE_BYTE          2'd0
`define SIZE_HALF          2'd1
`define SIZE_WORD          2'd2

`endif

// File: verilog/dccm_pkg.sv
// vector types for the two-bank DCCM; widths come from the consts header
`default_nettype none

`include "dccm_consts.svh"

package dccm_pkg;

   typedef logic [`DCCM_BITS-1:0]        dccm_addr_t;   // byte address
   typedef logic [`DCCM_DATA_WIDTH-1:0]  dccm_data_t;   // one bank of data
   typedef logic [`DCCM_ECC_WIDTH-1:0]   dccm_ecc_t;    // check bits of one bank
   typedef logic [`DCCM_FDATA_WIDTH-1:0] dccm_fdata_t;  // {ecc, data}
   typedef logic [`DCCM_BYTE_WIDTH-1:0]  byte_en_t;     // one bit per byte
   typedef logic [1:0]                   lsu_size_t;    // SIZE_* code

endpackage

`default_nettype wire

// File: verilog/dccm_port_arbiter.sv
// combinational only; the store buffer must hold its request until stbuf_commit is seen
`timescale 1ns/1ps
`default_nettype none

`include "dccm_consts.svh"

module dccm_port_arbiter
   import dccm_pkg::*;
(
   input  logic        ld_valid_d,        // load in D
   input  logic        st_valid_d,        // store in D
   input  lsu_size_t   size_d,
   input  dccm_addr_t  addr_d,            // first byte of the access
   input  dccm_addr_t  end_addr_d,        // last byte of the access
   input  logic        stbuf_reqvld,      // level request, held while waiting
   input  dccm_addr_t  stbuf_addr,
   input  dccm_data_t  stbuf_data,
   input  dccm_ecc_t   stbuf_ecc,
   input  logic        corr_pending,      // ECC write-back owns the port this cycle
   input  dccm_addr_t  corr_addr_lo,
   input  dccm_addr_t  corr_addr_hi,
   input  dccm_fdata_t corr_wdata_lo,
   input  dccm_fdata_t corr_wdata_hi,
   output logic        dccm_rden,
   output logic        stbuf_commit,
   output logic        dccm_wren,
   output dccm_addr_t  dccm_rd_addr_lo,
   output dccm_addr_t  dccm_rd_addr_hi,
   output dccm_addr_t  dccm_wr_addr_lo,
   output dccm_addr_t  dccm_wr_addr_hi,
   output dccm_fdata_t dccm_wr_data_lo,
   output dccm_fdata_t dccm_wr_data_hi
);

   logic                       st_needs_read;  // partial word store needs the old word
   logic [`DCCM_BANK_BITS-1:0] sb_bank;
   logic [`DCCM_BANK_BITS-1:0] lo_bank;
   logic [`DCCM_BANK_BITS-1:0] hi_bank;
   logic                       bank_conflict;
   dccm_fdata_t                stbuf_word;

   // an aligned full word store rewrites all check bits, so it skips the read
   assign st_needs_read = (size_d != `SIZE_WORD) |
                          (addr_d[`DCCM_WIDTH_BITS-1:0] != '0);
   assign dccm_rden     = ld_valid_d | (st_valid_d & st_needs_read);

   assign dccm_rd_addr_lo = addr_d;
   assign dccm_rd_addr_hi = end_addr_d;

   assign sb_bank = stbuf_addr[`DCCM_WIDTH_BITS +: `DCCM_BANK_BITS];
   assign lo_bank = addr_d[`DCCM_WIDTH_BITS +: `DCCM_BANK_BITS];
   assign hi_bank = end_addr_d[`DCCM_WIDTH_BITS +: `DCCM_BANK_BITS];

   // a read only blocks the store buffer when it touches the same bank
   assign bank_conflict = dccm_rden & ((sb_bank == lo_bank) | (sb_bank == hi_bank));

   assign stbuf_commit = stbuf_reqvld & ~corr_pending & ~bank_conflict;
   assign dccm_wren    = stbuf_commit | corr_pending;

   assign stbuf_word = {stbuf_ecc, stbuf_data};

   // correction write-back has priority over the store buffer
   assign dccm_wr_addr_lo = corr_pending ? corr_addr_lo  : stbuf_addr;
   assign dccm_wr_addr_hi = corr_pending ? corr_addr_hi  : stbuf_addr;
   assign dccm_wr_data_lo = corr_pending ? corr_wdata_lo : stbuf_word;
   assign dccm_wr_data_hi = corr_pending ? corr_wdata_hi : stbuf_word;

endmodule

`default_nettype wire

// File: verilog/ecc_correction_tracker.sv
// single-error inputs must already exclude forwarded banks; double errors are never corrected
`timescale 1ns/1ps
`default_nettype none

`include "dccm_consts.svh"

module ecc_correction_tracker
   import dccm_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ld_valid_r,             // read in R
   input  logic        commit_r,
   input  logic        single_ecc_error_lo_r,
   input  logic        single_ecc_error_hi_r,
   input  logic        double_ecc_error_r,
   input  dccm_addr_t  addr_r,
   input  dccm_addr_t  end_addr_r,
   input  dccm_data_t  sec_data_lo_r,          // corrected data from the decoder
   input  dccm_data_t  sec_data_hi_r,
   input  dccm_ecc_t   sec_ecc_lo_r,
   input  dccm_ecc_t   sec_ecc_hi_r,
   output logic        ld_single_ecc_error_r,
   output logic        corr_pending,           // write-back in R+1
   output dccm_addr_t  corr_addr_lo,
   output dccm_addr_t  corr_addr_hi,
   output dccm_fdata_t corr_wdata_lo,
   output dccm_fdata_t corr_wdata_hi
);

   logic        err_lo_r;
   logic        err_hi_r;
   logic        capture;      // committed load owes a write-back
   logic        err_lo_q;
   logic        err_hi_q;
   dccm_addr_t  addr_lo_q;
   dccm_addr_t  addr_hi_q;
   dccm_fdata_t word_lo_q;
   dccm_fdata_t word_hi_q;

   assign err_lo_r = ld_valid_r & single_ecc_error_lo_r & ~double_ecc_error_r;
   assign err_hi_r = ld_valid_r & single_ecc_error_hi_r & ~double_ecc_error_r;

   assign ld_single_ecc_error_r = err_lo_r | err_hi_r;
   assign capture               = ld_single_ecc_error_r & commit_r;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err_lo_q <= 1'b0;
         err_hi_q <= 1'b0;
      end else begin
         err_lo_q <= err_lo_r & commit_r;
         err_hi_q <= err_hi_r & commit_r;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         addr_lo_q <= addr_r;
         addr_hi_q <= end_addr_r;
         word_lo_q[`DCCM_DATA_WIDTH-1:0]                  <= sec_data_lo_r;
         word_lo_q[`DCCM_FDATA_WIDTH-1:`DCCM_DATA_WIDTH]  <= sec_ecc_lo_r;
         word_hi_q[`DCCM_DATA_WIDTH-1:0]                  <= sec_data_hi_r;
         word_hi_q[`DCCM_FDATA_WIDTH-1:`DCCM_DATA_WIDTH]  <= sec_ecc_hi_r;
      end
   end

   assign corr_pending = err_lo_q | err_hi_q;

   // a lone erring bank is mirrored onto the other port
   assign corr_addr_lo  = err_lo_q ? addr_lo_q : addr_hi_q;
   assign corr_addr_hi  = err_hi_q ? addr_hi_q : addr_lo_q;
   assign corr_wdata_lo = err_lo_q ? word_lo_q : word_hi_q;
   assign corr_wdata_hi = err_hi_q ? word_hi_q : word_lo_q;

endmodule

`default_nettype wire

// File: verilog/load_data_merge.sv
// read data arrives in M one cycle after dccm_rden; ld_data_r bytes above the size are don't-care
`timescale 1ns/1ps
`default_nettype none

`include "dccm_consts.svh"

module load_data_merge
   import dccm_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        dccm_rden,              // read issued in D
   input  dccm_addr_t  addr_d,
   input  dccm_addr_t  end_addr_d,
   input  dccm_fdata_t dccm_rd_data_lo,        // memory return in M
   input  dccm_fdata_t dccm_rd_data_hi,
   input  dccm_data_t  stbuf_fwddata_lo_m,
   input  dccm_data_t  stbuf_fwddata_hi_m,
   input  byte_en_t    stbuf_fwdbyteen_lo_m,
   input  byte_en_t    stbuf_fwdbyteen_hi_m,
   output logic        ld_valid_r,             // read valid in R
   output dccm_addr_t  addr_r,
   output dccm_addr_t  end_addr_r,
   output dccm_data_t  dccm_rdata_lo_r,
   output dccm_data_t  dccm_rdata_hi_r,
   output dccm_data_t  ld_data_r               // right-justified
);

   logic                            rden_m;
   dccm_addr_t                      addr_m;
   dccm_addr_t                      end_addr_m;
   logic                            dual_m;        // access crosses into the next word
   byte_en_t                        fwdbyteen_lo_r;
   byte_en_t                        fwdbyteen_hi_r;
   dccm_data_t                      fwddata_lo_r;
   dccm_data_t                      fwddata_hi_r;
   logic [2*`DCCM_DATA_WIDTH-1:0]   bank_data_r;
   logic [2*`DCCM_DATA_WIDTH-1:0]   fwd_data_r;
   logic [2*`DCCM_BYTE_WIDTH-1:0]   fwd_en_r;
   logic [2*`DCCM_DATA_WIDTH-1:0]   merged_r;
   logic [2*`DCCM_DATA_WIDTH-1:0]   shifted_r;

   assign dual_m = addr_m[`DCCM_BITS-1:`DCCM_WIDTH_BITS] !=
                   end_addr_m[`DCCM_BITS-1:`DCCM_WIDTH_BITS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rden_m         <= 1'b0;
         ld_valid_r     <= 1'b0;
         fwdbyteen_lo_r <= '0;
         fwdbyteen_hi_r <= '0;
      end else begin
         rden_m     <= dccm_rden;
         ld_valid_r <= rden_m;
         if (rden_m) begin
            fwdbyteen_lo_r <= stbuf_fwdbyteen_lo_m;
            fwdbyteen_hi_r <= stbuf_fwdbyteen_hi_m;
         end
      end
   end

   // payload only moves with a read, so R holds until the next one
   always_ff @(posedge clk) begin
      if (dccm_rden) begin
         addr_m     <= addr_d;
         end_addr_m <= end_addr_d;
      end
      if (rden_m) begin
         addr_r          <= addr_m;
         end_addr_r      <= end_addr_m;
         dccm_rdata_lo_r <= dccm_rd_data_lo[`DCCM_DATA_WIDTH-1:0];  // check bits dropped
         fwddata_lo_r    <= stbuf_fwddata_lo_m;
         fwddata_hi_r    <= stbuf_fwddata_hi_m;
      end
      if (rden_m && dual_m) begin
         dccm_rdata_hi_r <= dccm_rd_data_hi[`DCCM_DATA_WIDTH-1:0];
      end
   end

   assign bank_data_r = {dccm_rdata_hi_r, dccm_rdata_lo_r};
   assign fwd_data_r  = {fwddata_hi_r, fwddata_lo_r};
   assign fwd_en_r    = {fwdbyteen_hi_r, fwdbyteen_lo_r};

   // forwarded store-buffer bytes win over memory bytes
   always_comb begin
      for (int i = 0; i < 2*`DCCM_BYTE_WIDTH; i++) begin
         merged_r[8*i +: 8] = fwd_en_r[i] ? fwd_data_r[8*i +: 8] : bank_data_r[8*i +: 8];
      end
   end

   assign shifted_r = merged_r >> {addr_r[`DCCM_WIDTH_BITS-1:0], 3'b000};
   assign ld_data_r = shifted_r[`DCCM_DATA_WIDTH-1:0];

endmodule

`default_nettype wire

// File: verilog/dccm_ctl.sv
// no DMA, PIC or clock gating; ECC encode and decode sit outside and feed the R-stage inputs
`timescale 1ns/1ps
`default_nettype none

`include "dccm_consts.svh"

module dccm_ctl
   import dccm_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ld_valid_d,
   input  logic        st_valid_d,
   input  lsu_size_t   size_d,
   input  dccm_addr_t  addr_d,
   input  logic        stbuf_reqvld,
   input  dccm_addr_t  stbuf_addr,
   input  dccm_data_t  stbuf_data,
   input  dccm_ecc_t   stbuf_ecc,
   input  dccm_data_t  stbuf_fwddata_lo_m,
   input  dccm_data_t  stbuf_fwddata_hi_m,
   input  byte_en_t    stbuf_fwdbyteen_lo_m,
   input  byte_en_t    stbuf_fwdbyteen_hi_m,
   input  logic        commit_r,
   input  logic        single_ecc_error_lo_r,
   input  logic        single_ecc_error_hi_r,
   input  logic        double_ecc_error_r,
   input  dccm_data_t  sec_data_lo_r,
   input  dccm_data_t  sec_data_hi_r,
   input  dccm_ecc_t   sec_ecc_lo_r,
   input  dccm_ecc_t   sec_ecc_hi_r,
   input  dccm_fdata_t dccm_rd_data_lo,
   input  dccm_fdata_t dccm_rd_data_hi,
   output logic        dccm_rden,
   output dccm_addr_t  dccm_rd_addr_lo,
   output dccm_addr_t  dccm_rd_addr_hi,
   output logic        dccm_wren,
   output dccm_addr_t  dccm_wr_addr_lo,
   output dccm_addr_t  dccm_wr_addr_hi,
   output dccm_fdata_t dccm_wr_data_lo,
   output dccm_fdata_t dccm_wr_data_hi,
   output dccm_data_t  ld_data_r,
   output dccm_data_t  dccm_rdata_lo_r,
   output dccm_data_t  dccm_rdata_hi_r,
   output logic        ld_single_ecc_error_r,
   output logic        stbuf_commit
);

   logic [1:0]  size_off;     // bytes in the access minus one
   dccm_addr_t  end_addr_d;
   logic        corr_pending;
   dccm_addr_t  corr_addr_lo;
   dccm_addr_t  corr_addr_hi;
   dccm_fdata_t corr_wdata_lo;
   dccm_fdata_t corr_wdata_hi;
   logic        ld_valid_r;
   dccm_addr_t  addr_r;
   dccm_addr_t  end_addr_r;

   always_comb begin
      case (size_d)
         `SIZE_BYTE: size_off = 2'd0;
         `SIZE_HALF: size_off = 2'd1;
         default:    size_off = 2'd3;  // word
      endcase
   end

   assign end_addr_d = addr_d + dccm_addr_t'(size_off);

   dccm_port_arbiter arb_i (
      .ld_valid_d, .st_valid_d, .size_d, .addr_d, .end_addr_d,
      .stbuf_reqvld, .stbuf_addr, .stbuf_data, .stbuf_ecc,
      .corr_pending, .corr_addr_lo, .corr_addr_hi, .corr_wdata_lo, .corr_wdata_hi,
      .dccm_rden, .stbuf_commit, .dccm_wren,
      .dccm_rd_addr_lo, .dccm_rd_addr_hi, .dccm_wr_addr_lo, .dccm_wr_addr_hi,
      .dccm_wr_data_lo, .dccm_wr_data_hi
   );

   ecc_correction_tracker corr_i (
      .clk, .rst_n, .ld_valid_r, .commit_r,
      .single_ecc_error_lo_r, .single_ecc_error_hi_r, .double_ecc_error_r,
      .addr_r, .end_addr_r, .sec_data_lo_r, .sec_data_hi_r, .sec_ecc_lo_r, .sec_ecc_hi_r,
      .ld_single_ecc_error_r, .corr_pending,
      .corr_addr_lo, .corr_addr_hi, .corr_wdata_lo, .corr_wdata_hi
   );

   load_data_merge merge_i (
      .clk, .rst_n, .dccm_rden, .addr_d, .end_addr_d,
      .dccm_rd_data_lo, .dccm_rd_data_hi,
      .stbuf_fwddata_lo_m, .stbuf_fwddata_hi_m, .stbuf_fwdbyteen_lo_m, .stbuf_fwdbyteen_hi_m,
      .ld_valid_r, .addr_r, .end_addr_r, .dccm_rdata_lo_r, .dccm_rdata_hi_r, .ld_data_r
   );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// free-running 10 ns clock; rst_n is released on a rising edge after 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// File: verification/dccm_ctl_tb.sv
// directed tests; model words are filled from their own address, the memory model skips ECC checks
`timescale 1ns/1ps
`default_nettype none

`include "dccm_consts.svh"

module dccm_ctl_tb
   import dccm_pkg::*;
();

   localparam int WORDS           = 1 << (`DCCM_BITS - `DCCM_WIDTH_BITS);
   localparam int WATCHDOG_CYCLES = 2000;  // roughly 200 cycles of tests plus margin

   logic        clk, rst_n;
   logic        ld_valid_d, st_valid_d, stbuf_reqvld;
   lsu_size_t   size_d;
   dccm_addr_t  addr_d, stbuf_addr;
   dccm_data_t  stbuf_data, stbuf_fwddata_lo_m, stbuf_fwddata_hi_m;
   dccm_ecc_t   stbuf_ecc, sec_ecc_lo_r, sec_ecc_hi_r;
   byte_en_t    stbuf_fwdbyteen_lo_m, stbuf_fwdbyteen_hi_m;
   logic        commit_r, single_ecc_error_lo_r, single_ecc_error_hi_r, double_ecc_error_r;
   dccm_data_t  sec_data_lo_r, sec_data_hi_r;
   dccm_fdata_t dccm_rd_data_lo = '0;  // driven by the memory model
   dccm_fdata_t dccm_rd_data_hi = '0;
   logic        dccm_rden, dccm_wren, ld_single_ecc_error_r, stbuf_commit;
   dccm_addr_t  dccm_rd_addr_lo, dccm_rd_addr_hi, dccm_wr_addr_lo, dccm_wr_addr_hi;
   dccm_fdata_t dccm_wr_data_lo, dccm_wr_data_hi;
   dccm_data_t  ld_data_r, dccm_rdata_lo_r, dccm_rdata_hi_r;
   dccm_fdata_t bank_mem [WORDS];      // both banks, indexed by addr[15:2]

   tb_clock_gen clk_gen_i (.clk, .rst_n);
   dccm_ctl dut_i (.*);

   function automatic dccm_fdata_t fill_word(input int idx);
      return {7'(idx), 32'(idx) * 32'h9e37_79b1 ^ 32'h0f1e_2d3c};
   endfunction

   // reads answer one cycle after dccm_rden, writes land at the edge that ends the wren cycle
   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < WORDS; i++) begin
            bank_mem[i] <= fill_word(i);
         end
      end else begin
         if (dccm_rden) begin
            dccm_rd_data_lo <= bank_mem[dccm_rd_addr_lo[`DCCM_BITS-1:`DCCM_WIDTH_BITS]];
            dccm_rd_data_hi <= bank_mem[dccm_rd_addr_hi[`DCCM_BITS-1:`DCCM_WIDTH_BITS]];
         end
         if (dccm_wren) begin
            bank_mem[dccm_wr_addr_lo[`DCCM_BITS-1:`DCCM_WIDTH_BITS]] <= dccm_wr_data_lo;
            bank_mem[dccm_wr_addr_hi[`DCCM_BITS-1:`DCCM_WIDTH_BITS]] <= dccm_wr_data_hi;
         end
      end
   end

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
      assert (got === exp) else begin
         $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   // word index kept one below the top so a crossing access stays in range
   function automatic dccm_addr_t random_addr(input logic [1:0] offset);
      return (dccm_addr_t'($urandom_range(WORDS - 2)) << `DCCM_WIDTH_BITS) |
             dccm_addr_t'(offset);
   endfunction

   function automatic dccm_data_t expected_load(input dccm_addr_t addr, input lsu_size_t size,
                                                input logic [7:0] fwd_en,
                                                input logic [63:0] fwd_data);
      dccm_data_t result;
      dccm_addr_t byte_addr;
      int         lane;
      int         nbytes;
      result = '0;
      nbytes = (size == `SIZE_BYTE) ? 1 : (size == `SIZE_HALF) ? 2 : 4;
      for (int k = 0; k < nbytes; k++) begin
         byte_addr = addr + dccm_addr_t'(k);
         lane      = int'(addr[1:0]) + k;  // lanes 4..7 belong to the next word
         if (fwd_en[lane])
            result[8*k +: 8] = fwd_data[8*lane +: 8];
         else
            result[8*k +: 8] = bank_mem[byte_addr[`DCCM_BITS-1:2]][8*byte_addr[1:0] +: 8];
      end
      return result;
   endfunction

   // walks one load through D and M and returns at the start of its R cycle
   task automatic load_to_r(input dccm_addr_t addr, input lsu_size_t size,
                            input logic [7:0] fwd_en, input logic [63:0] fwd_data);
      @(posedge clk);
      ld_valid_d <= 1'b1;
      size_d     <= size;
      addr_d     <= addr;
      @(posedge clk);
      ld_valid_d           <= 1'b0;
      stbuf_fwdbyteen_lo_m <= fwd_en[3:0];
      stbuf_fwdbyteen_hi_m <= fwd_en[7:4];
      stbuf_fwddata_lo_m   <= fwd_data[31:0];
      stbuf_fwddata_hi_m   <= fwd_data[63:32];
      @(posedge clk);
      stbuf_fwdbyteen_lo_m <= '0;
      stbuf_fwdbyteen_hi_m <= '0;
   endtask

   task automatic check_load(input dccm_addr_t addr, input lsu_size_t size,
                             input logic [7:0] fwd_en, input logic [63:0] fwd_data);
      dccm_data_t mask;
      dccm_addr_t word_idx;
      int         nbytes;
      load_to_r(addr, size, fwd_en, fwd_data);
      @(negedge clk);
      mask = (size == `SIZE_BYTE) ? 32'hff : (size == `SIZE_HALF) ? 32'hffff : 32'hffff_ffff;
      check_value(64'(ld_data_r & mask), 64'(expected_load(addr, size, fwd_en, fwd_data)),
                  $sformatf("ld_data_r for size %0d at %h", size, addr));
      nbytes   = (size == `SIZE_BYTE) ? 1 : (size == `SIZE_HALF) ? 2 : 4;
      word_idx = addr >> `DCCM_WIDTH_BITS;
      check_value(64'(dccm_rdata_lo_r), 64'(bank_mem[word_idx][`DCCM_DATA_WIDTH-1:0]),
                  $sformatf("dccm_rdata_lo_r at %h", addr));
      if (int'(addr[1:0]) + nbytes > `DCCM_BYTE_WIDTH)  // hi word only on a crossing
         check_value(64'(dccm_rdata_hi_r), 64'(bank_mem[word_idx + 1][`DCCM_DATA_WIDTH-1:0]),
                     $sformatf("dccm_rdata_hi_r at %h", addr));
   endtask

   task automatic test_load_justify();
      for (int s = 0; s < 3; s++) begin
         for (int off = 0; off < `DCCM_BYTE_WIDTH; off++) begin
            check_load(random_addr(2'(off)), lsu_size_t'(s), 8'h00, 64'h0);
         end
      end
   endtask

   task automatic test_load_forward();
      for (int n = 0; n < 12; n++) begin
         check_load(random_addr(2'($urandom)), lsu_size_t'($urandom_range(2)),
                    8'($urandom), {$urandom, $urandom});
      end
   endtask

   task automatic test_store_rden();
      @(posedge clk);
      st_valid_d <= 1'b1;
      size_d     <= `SIZE_WORD;
      addr_d     <= random_addr(2'd0);
      @(negedge clk);
      check_value(64'(dccm_rden), 64'd0, "dccm_rden on aligned word store");
      @(posedge clk);
      size_d <= `SIZE_BYTE;
      @(negedge clk);
      check_value(64'(dccm_rden), 64'd1, "dccm_rden on byte store");
      @(posedge clk);
      size_d <= `SIZE_WORD;
      addr_d <= random_addr(2'd1);
      @(negedge clk);
      check_value(64'(dccm_rden), 64'd1, "dccm_rden on unaligned word store");
      @(posedge clk);
      st_valid_d <= 1'b0;
   endtask

   task automatic test_stbuf_arbitration();
      dccm_addr_t ld_addr;
      dccm_addr_t sb_addr;
      dccm_data_t sb_data;
      dccm_ecc_t  sb_ecc;
      sb_addr = random_addr(2'd0);
      sb_data = $urandom;
      sb_ecc  = 7'($urandom);
      @(posedge clk);
      stbuf_reqvld <= 1'b1;
      stbuf_addr   <= sb_addr;
      stbuf_data   <= sb_data;
      stbuf_ecc    <= sb_ecc;
      @(negedge clk);
      check_value(64'({stbuf_commit, dccm_wren}), 64'b11, "commit and wren with idle port");
      @(posedge clk);
      stbuf_reqvld <= 1'b0;
      @(negedge clk);
      check_value(64'(bank_mem[sb_addr[`DCCM_BITS-1:2]]), 64'({sb_ecc, sb_data}),
                  "memory after store-buffer write");
      ld_addr = random_addr(2'd0);
      sb_addr[`DCCM_WIDTH_BITS] = ld_addr[`DCCM_WIDTH_BITS];  // same bank as the load
      @(posedge clk);
      ld_valid_d   <= 1'b1;
      size_d       <= `SIZE_WORD;
      addr_d       <= ld_addr;
      stbuf_reqvld <= 1'b1;
      stbuf_addr   <= sb_addr;
      @(negedge clk);
      check_value(64'(stbuf_commit), 64'd0, "stbuf_commit during same-bank load");
      @(posedge clk);
      stbuf_addr <= sb_addr ^ dccm_addr_t'(1 << `DCCM_WIDTH_BITS);
      @(negedge clk);
      check_value(64'({stbuf_commit, dccm_wren}), 64'b11, "commit during other-bank load");
      @(posedge clk);
      ld_valid_d   <= 1'b0;
      stbuf_reqvld <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   task automatic test_ecc_writeback();
      dccm_addr_t addr;
      dccm_data_t fixed;
      dccm_ecc_t  fixed_ecc;
      addr      = random_addr(2'd0);
      fixed     = $urandom;
      fixed_ecc = 7'($urandom);
      load_to_r(addr, `SIZE_WORD, 8'h00, 64'h0);
      commit_r              <= 1'b1;
      single_ecc_error_lo_r <= 1'b1;
      sec_data_lo_r         <= fixed;
      sec_ecc_lo_r          <= fixed_ecc;
      @(negedge clk);
      check_value(64'(ld_single_ecc_error_r), 64'd1, "ld_single_ecc_error_r in R");
      @(posedge clk);
      commit_r              <= 1'b0;
      single_ecc_error_lo_r <= 1'b0;
      stbuf_reqvld          <= 1'b1;
      stbuf_addr            <= random_addr(2'd0);
      @(negedge clk);
      check_value(64'({dccm_wren, stbuf_commit}), 64'b10, "correction wins the write port");
      check_value(64'(dccm_wr_addr_lo), 64'(addr), "correction write address");
      check_value(64'(dccm_wr_addr_hi), 64'(addr), "mirrored hi write address");
      check_value(64'(dccm_wr_data_lo), 64'({fixed_ecc, fixed}), "corrected lo word");
      check_value(64'(dccm_wr_data_hi), 64'({fixed_ecc, fixed}), "mirrored hi word");
      @(posedge clk);
      @(negedge clk);
      check_value(64'(stbuf_commit), 64'd1, "stbuf_commit after the correction cycle");
      @(posedge clk);
      stbuf_reqvld <= 1'b0;
   endtask

   task automatic test_ecc_suppressed();
      load_to_r(random_addr(2'd0), `SIZE_WORD, 8'h00, 64'h0);
      commit_r              <= 1'b1;
      single_ecc_error_lo_r <= 1'b1;
      double_ecc_error_r    <= 1'b1;
      @(negedge clk);
      check_value(64'(ld_single_ecc_error_r), 64'd0, "single error flag with double error");
      @(posedge clk);
      commit_r           <= 1'b0;
      double_ecc_error_r <= 1'b0;
      @(negedge clk);
      check_value(64'(dccm_wren), 64'd0, "dccm_wren after double error");
      load_to_r(random_addr(2'd0), `SIZE_WORD, 8'h00, 64'h0);  // error still set, no commit
      @(posedge clk);
      single_ecc_error_lo_r <= 1'b0;
      @(negedge clk);
      check_value(64'(dccm_wren), 64'd0, "dccm_wren after uncommitted load");
   endtask

   initial begin
      void'($urandom(32'h3d20_4dcb));
      ld_valid_d            <= 1'b0;
      st_valid_d            <= 1'b0;
      size_d                <= `SIZE_BYTE;
      addr_d                <= '0;
      stbuf_reqvld          <= 1'b0;
      stbuf_addr            <= '0;
      stbuf_data            <= '0;
      stbuf_ecc             <= '0;
      stbuf_fwddata_lo_m    <= '0;
      stbuf_fwddata_hi_m    <= '0;
      stbuf_fwdbyteen_lo_m  <= '0;
      stbuf_fwdbyteen_hi_m  <= '0;
      commit_r              <= 1'b0;
      single_ecc_error_lo_r <= 1'b0;
      single_ecc_error_hi_r <= 1'b0;
      double_ecc_error_r    <= 1'b0;
      sec_data_lo_r         <= '0;
      sec_data_hi_r         <= '0;
      sec_ecc_lo_r          <= '0;
      sec_ecc_hi_r          <= '0;
      wait (rst_n === 1'b1);
      test_load_justify();
      test_load_forward();
      test_store_rden();
      test_stbuf_arbitration();
      test_ecc_writeback();
      test_ecc_suppressed();
      repeat (4) @(posedge clk);
      $display("Verification passed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Verification failed");
      $fatal(1);
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/dccm_pkg.sv
verilog/dccm_port_arbiter.sv
verilog/ecc_correction_tracker.sv
verilog/load_data_merge.sv
verilog/dccm_ctl.sv
verification/tb_clock_gen.sv
verification/dccm_ctl_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := dccm_ctl_tb
FILELIST := all.f
OBJ_DIR  := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
